// File: hdl/dec_pkg.sv
`default_nettype none

package dec_pkg;

   // predictor hint width, fixed by the predictor format
   localparam int HINT_W = 4;

   // decoded operation class
   typedef enum logic [2:0] {
      OP_ALU     = 3'd0,
      OP_LUI     = 3'd1,
      OP_LOAD    = 3'd2,
      OP_STORE   = 3'd3,
      OP_BRANCH  = 3'd4,
      OP_SYSCALL = 3'd5,
      OP_BREAK   = 3'd6,
      OP_INE     = 3'd7
   } op_class_t;

   // branch unit code
   typedef enum logic [2:0] {
      BRU_NONE = 3'd0,
      BRU_BEQ  = 3'd1,
      BRU_BNE  = 3'd2,
      BRU_B    = 3'd3,
      BRU_BL   = 3'd4,
      BRU_JIRL = 3'd5
   } bru_code_t;

   // LoongArch exccode table subset
   // INT shares code 0, the exception bit tells it apart from no exception
   typedef enum logic [5:0] {
      EXC_INT = 6'h00,
      EXC_SYS = 6'h0b,
      EXC_BRK = 6'h0c,
      EXC_INE = 6'h0d
   } exccode_t;

   localparam exccode_t EXC_NONE = EXC_INT;

   // immediate field kind
   typedef enum logic [1:0] {
      IMM_SI12   = 2'd0,
      IMM_SI20   = 2'd1,
      IMM_OFFS16 = 2'd2,
      IMM_OFFS26 = 2'd3
   } imm_sel_t;

   typedef struct packed {
      op_class_t op_class;
      bru_code_t bru_code;
      logic      gr_wen;
      logic      uses_imm;
      imm_sel_t  imm_sel;
   } dec_op_t;

   // fetch packet payload, 44 bits
   typedef struct packed {
      logic [31:0]       inst;
      logic              br_taken;
      logic              exception;
      logic [5:0]        exccode;
      logic [HINT_W-1:0] hint;
   } fetch_info_t;

   // 3R format, opcode in inst[31:15]
   localparam logic [16:0] OPC_ADD_W   = 17'h00020;
   localparam logic [16:0] OPC_SUB_W   = 17'h00022;
   // code field in inst[14:0], any value
   localparam logic [16:0] OPC_BREAK   = 17'h00054;
   localparam logic [16:0] OPC_SYSCALL = 17'h00056;

   // 2RI12 format, opcode in inst[31:22]
   localparam logic [9:0]  OPC_ADDI_W  = 10'h00a;
   localparam logic [9:0]  OPC_LD_W    = 10'h0a2;
   localparam logic [9:0]  OPC_ST_W    = 10'h0a6;

   // 1RI20 format, opcode in inst[31:25]
   localparam logic [6:0]  OPC_LU12I_W = 7'h0a;

   // branch formats, opcode in inst[31:26]
   localparam logic [5:0]  OPC_JIRL    = 6'h13;
   localparam logic [5:0]  OPC_B       = 6'h14;
   localparam logic [5:0]  OPC_BL      = 6'h15;
   localparam logic [5:0]  OPC_BEQ     = 6'h16;
   localparam logic [5:0]  OPC_BNE     = 6'h17;

   // BL links into r1
   localparam logic [4:0]  LINK_REG    = 5'd1;

endpackage

`default_nettype wire

// File: hdl/inst_decoder.sv
`default_nettype none

module inst_decoder import dec_pkg::*; (
   input  wire [31:0] inst,
   output dec_op_t    op
);

   // major opcode slices for each format
   logic [16:0] op17;
   logic [9:0]  op10;
   logic [6:0]  op7;
   logic [5:0]  op6;

   // one match line per supported instruction
   logic is_add_w;
   logic is_sub_w;
   logic is_addi_w;
   logic is_lu12i_w;
   logic is_ld_w;
   logic is_st_w;
   logic is_beq;
   logic is_bne;
   logic is_b;
   logic is_bl;
   logic is_jirl;
   logic is_syscall;
   logic is_break;

   // class and branch code before the write-enable rule
   op_class_t cls;
   bru_code_t bru;
   logic      uses_imm;
   imm_sel_t  imm_sel;

   assign op17 = inst[31:15];
   assign op10 = inst[31:22];
   assign op7  = inst[31:25];
   assign op6  = inst[31:26];

   // 3R and trap encodings
   assign is_add_w   = (op17 == OPC_ADD_W);
   assign is_sub_w   = (op17 == OPC_SUB_W);
   assign is_syscall = (op17 == OPC_SYSCALL);
   assign is_break   = (op17 == OPC_BREAK);

   // 2RI12 encodings
   assign is_addi_w  = (op10 == OPC_ADDI_W);
   assign is_ld_w    = (op10 == OPC_LD_W);
   assign is_st_w    = (op10 == OPC_ST_W);

   // 1RI20
   assign is_lu12i_w = (op7 == OPC_LU12I_W);

   // branches and jumps
   assign is_jirl    = (op6 == OPC_JIRL);
   assign is_b       = (op6 == OPC_B);
   assign is_bl      = (op6 == OPC_BL);
   assign is_beq     = (op6 == OPC_BEQ);
   assign is_bne     = (op6 == OPC_BNE);

   // encodings are disjoint, so chain order does not matter
   always_comb begin
      // anything unmatched falls through as INE
      cls      = OP_INE;
      bru      = BRU_NONE;
      uses_imm = 1'b0;
      imm_sel  = IMM_SI12;

      if (is_add_w || is_sub_w) begin
         cls = OP_ALU;
      end else if (is_addi_w) begin
         cls      = OP_ALU;
         uses_imm = 1'b1;
      end else if (is_lu12i_w) begin
         cls      = OP_LUI;
         uses_imm = 1'b1;
         imm_sel  = IMM_SI20;
      end else if (is_ld_w) begin
         cls      = OP_LOAD;
         uses_imm = 1'b1;
      end else if (is_st_w) begin
         cls      = OP_STORE;
         uses_imm = 1'b1;
      end else if (is_beq || is_bne) begin
         // conditional branches, offs16
         cls      = OP_BRANCH;
         bru      = is_beq ? BRU_BEQ : BRU_BNE;
         uses_imm = 1'b1;
         imm_sel  = IMM_OFFS16;
      end else if (is_jirl) begin
         // register-relative jump, offs16 as well
         cls      = OP_BRANCH;
         bru      = BRU_JIRL;
         uses_imm = 1'b1;
         imm_sel  = IMM_OFFS16;
      end else if (is_b || is_bl) begin
         // pc-relative, offs26
         cls      = OP_BRANCH;
         bru      = is_bl ? BRU_BL : BRU_B;
         uses_imm = 1'b1;
         imm_sel  = IMM_OFFS26;
      end else if (is_syscall) begin
         cls = OP_SYSCALL;
      end else if (is_break) begin
         cls = OP_BREAK;
      end
   end

   always_comb begin
      op.op_class = cls;
      op.bru_code = bru;
      op.uses_imm = uses_imm;
      op.imm_sel  = imm_sel;
      // writers: alu, lui, load, and the two linking jumps
      op.gr_wen   = (cls == OP_ALU) || (cls == OP_LUI) || (cls == OP_LOAD) ||
                    (bru == BRU_BL) || (bru == BRU_JIRL);
   end

endmodule

`default_nettype wire

// File: hdl/int_pending.sv
`default_nettype none

module int_pending (
   input  wire  clk,
   input  wire  rst,
   input  wire  irq,
   input  wire  int_taken,
   output logic int_except
);

   // sticky request flag
   logic pending;

   // set wins over clear
   // a new irq in the cycle of a take stays for the next instruction
   always_ff @(posedge clk) begin
      if (rst) begin
         pending <= 1'b0;
      end else if (irq) begin
         pending <= 1'b1;
      end else if (int_taken) begin
         pending <= 1'b0;
      end
   end

   // level seen by the stage, attached to the next valid decode
   assign int_except = pending;

endmodule

`default_nettype wire

// File: hdl/ifu_dec_stage.sv
`default_nettype none

module ifu_dec_stage import dec_pkg::*; #(
   parameter int grlen = 32
) (
   input  wire               clk,
   input  wire               rst,
   input  wire               fetch_valid,
   input  wire [grlen-1:0]   fetch_pc,
   input  wire [grlen-3:0]   fetch_br_target,
   input  wire fetch_info_t  fetch_info,
   input  wire               int_except,
   output logic              dec_valid,
   output logic [grlen-1:0]  dec_pc,
   output logic [grlen-3:0]  dec_br_target,
   output fetch_info_t       dec_info,
   output dec_op_t           dec_op,
   output logic              rf_wen,
   output logic [4:0]        rf_target,
   output logic              int_taken
);

   // registered fetch payload, exception fields still raw
   fetch_info_t info_q;

   // decoded trap causes
   logic is_sys;
   logic is_brk;
   logic is_ine;

   // merged result
   logic       exc_any;
   logic [5:0] exc_code;
   logic [4:0] waddr;

   // valid follows fetch every cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= fetch_valid;
      end
   end

   // payload loads only on a fetch strobe, holds otherwise
   always_ff @(posedge clk) begin
      if (rst) begin
         dec_pc        <= '0;
         dec_br_target <= '0;
         info_q        <= '0;
      end else if (fetch_valid) begin
         dec_pc        <= fetch_pc;
         dec_br_target <= fetch_br_target;
         info_q        <= fetch_info;
      end
   end

   // decode straight off the registered word
   inst_decoder u_inst_decoder (
      .inst (info_q.inst),
      .op   (dec_op)
   );

   assign is_sys = (dec_op.op_class == OP_SYSCALL);
   assign is_brk = (dec_op.op_class == OP_BREAK);
   assign is_ine = (dec_op.op_class == OP_INE);

   // exception bit is the or of every cause
   assign exc_any = int_except | info_q.exception | is_sys | is_brk | is_ine;

   // code by fixed priority: int, fetch, sys, brk, ine
   always_comb begin
      if (int_except) begin
         exc_code = EXC_INT;
      end else if (info_q.exception) begin
         exc_code = info_q.exccode;
      end else if (is_sys) begin
         exc_code = EXC_SYS;
      end else if (is_brk) begin
         exc_code = EXC_BRK;
      end else if (is_ine) begin
         exc_code = EXC_INE;
      end else begin
         exc_code = EXC_NONE;
      end
   end

   // merged exception goes out, not the raw fetch one
   always_comb begin
      dec_info           = info_q;
      dec_info.exception = exc_any;
      dec_info.exccode   = exc_code;
   end

   // faulting instruction never writes
   assign rf_wen = dec_op.gr_wen & dec_valid & ~exc_any;

   // BL links into r1, the rest target rd
   assign waddr     = (dec_op.bru_code == BRU_BL) ? LINK_REG : info_q.inst[4:0];
   assign rf_target = {5{rf_wen}} & waddr;

   // interrupt consumed by this valid instruction
   assign int_taken = dec_valid & int_except;

endmodule

`default_nettype wire

// File: hdl/ifu_dec_top.sv
`default_nettype none

module ifu_dec_top import dec_pkg::*; #(
   parameter int grlen = 32
) (
   input  wire               clk,
   input  wire               rst,
   // fetch side
   input  wire               fetch_valid,
   input  wire [grlen-1:0]   fetch_pc,
   input  wire [grlen-3:0]   fetch_br_target,
   input  wire fetch_info_t  fetch_info,
   // external interrupt pulse
   input  wire               irq,
   // execution side
   output logic              dec_valid,
   output logic [grlen-1:0]  dec_pc,
   output logic [grlen-3:0]  dec_br_target,
   output fetch_info_t       dec_info,
   output dec_op_t           dec_op,
   output logic              rf_wen,
   output logic [4:0]        rf_target
);

   // pending interrupt level and its take pulse
   logic int_except;
   logic int_taken;

   int_pending u_int_pending (
      .clk        (clk),
      .rst        (rst),
      .irq        (irq),
      .int_taken  (int_taken),
      .int_except (int_except)
   );

   // single decode slot, grlen passed down
   ifu_dec_stage #(
      .grlen (grlen)
   ) u_ifu_dec_stage (
      .clk             (clk),
      .rst             (rst),
      .fetch_valid     (fetch_valid),
      .fetch_pc        (fetch_pc),
      .fetch_br_target (fetch_br_target),
      .fetch_info      (fetch_info),
      .int_except      (int_except),
      .dec_valid       (dec_valid),
      .dec_pc          (dec_pc),
      .dec_br_target   (dec_br_target),
      .dec_info        (dec_info),
      .dec_op          (dec_op),
      .rf_wen          (rf_wen),
      .rf_target       (rf_target),
      .int_taken       (int_taken)
   );

endmodule

`default_nettype wire

// File: testbench/tb_ifu_dec_top.sv
`default_nettype none

module tb_ifu_dec_top import dec_pkg::*; ();

   localparam int GRLEN    = 32;
   localparam int N_CYCLES = 1800;
   // 2000 cycles of 20 units plus margin
   localparam int TIMEOUT  = 2000 * 20 + 2000;

   logic               clk;
   logic               rst;
   logic               fetch_valid;
   logic [GRLEN-1:0]   fetch_pc;
   logic [GRLEN-3:0]   fetch_br_target;
   fetch_info_t        fetch_info;
   logic               irq;
   logic               dec_valid;
   logic [GRLEN-1:0]   dec_pc;
   logic [GRLEN-3:0]   dec_br_target;
   fetch_info_t        dec_info;
   dec_op_t            dec_op;
   logic               rf_wen;
   logic [4:0]         rf_target;

   // expected decode of the word being driven, from the encoding table
   dec_op_t stim_op;

   // one-entry reference model
   logic             m_valid;
   logic [GRLEN-1:0] m_pc;
   logic [GRLEN-3:0] m_bt;
   fetch_info_t      m_info;
   dec_op_t          m_op;
   logic             m_pend;

   // expected outputs
   logic       exp_exc;
   logic [5:0] exp_code;
   logic       exp_wen;
   logic [4:0] exp_target;

   logic [15:0] lfsr;

   ifu_dec_top #(
      .grlen (GRLEN)
   ) UUT (
      .clk             (clk),
      .rst             (rst),
      .fetch_valid     (fetch_valid),
      .fetch_pc        (fetch_pc),
      .fetch_br_target (fetch_br_target),
      .fetch_info      (fetch_info),
      .irq             (irq),
      .dec_valid       (dec_valid),
      .dec_pc          (dec_pc),
      .dec_br_target   (dec_br_target),
      .dec_info        (dec_info),
      .dec_op          (dec_op),
      .rf_wen          (rf_wen),
      .rf_target       (rf_target)
   );

   always #10 clk = ~clk;

   // 16-bit fibonacci lfsr, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   // one lfsr step per bit taken
   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   // instruction word of a table kind, r fills register and immediate fields
   function automatic logic [31:0] inst_word(input int kind, input logic [31:0] r);
      case (kind)
         0:  return {OPC_ADD_W, r[14:0]};
         1:  return {OPC_SUB_W, r[14:0]};
         2:  return {OPC_ADDI_W, r[21:0]};
         3:  return {OPC_LU12I_W, r[24:0]};
         4:  return {OPC_LD_W, r[21:0]};
         5:  return {OPC_ST_W, r[21:0]};
         6:  return {OPC_BEQ, r[25:0]};
         7:  return {OPC_BNE, r[25:0]};
         8:  return {OPC_B, r[25:0]};
         9:  return {OPC_BL, r[25:0]};
         10: return {OPC_JIRL, r[25:0]};
         11: return {OPC_SYSCALL, r[14:0]};
         12: return {OPC_BREAK, r[14:0]};
         // bit 31 set matches no supported opcode
         default: return {1'b1, r[30:0]};
      endcase
   endfunction

   // class, branch code, write enable and immediate kind per table kind
   function automatic dec_op_t expected_op(input int kind);
      case (kind)
         0, 1:    return '{OP_ALU, BRU_NONE, 1'b1, 1'b0, IMM_SI12};
         2:       return '{OP_ALU, BRU_NONE, 1'b1, 1'b1, IMM_SI12};
         3:       return '{OP_LUI, BRU_NONE, 1'b1, 1'b1, IMM_SI20};
         4:       return '{OP_LOAD, BRU_NONE, 1'b1, 1'b1, IMM_SI12};
         5:       return '{OP_STORE, BRU_NONE, 1'b0, 1'b1, IMM_SI12};
         6:       return '{OP_BRANCH, BRU_BEQ, 1'b0, 1'b1, IMM_OFFS16};
         7:       return '{OP_BRANCH, BRU_BNE, 1'b0, 1'b1, IMM_OFFS16};
         8:       return '{OP_BRANCH, BRU_B, 1'b0, 1'b1, IMM_OFFS26};
         9:       return '{OP_BRANCH, BRU_BL, 1'b1, 1'b1, IMM_OFFS26};
         10:      return '{OP_BRANCH, BRU_JIRL, 1'b1, 1'b1, IMM_OFFS16};
         11:      return '{OP_SYSCALL, BRU_NONE, 1'b0, 1'b0, IMM_SI12};
         12:      return '{OP_BREAK, BRU_NONE, 1'b0, 1'b0, IMM_SI12};
         default: return '{OP_INE, BRU_NONE, 1'b0, 1'b0, IMM_SI12};
      endcase
   endfunction

   // one random cycle of fetch traffic and irq
   task automatic drive_cycle();
      logic [31:0] r;
      int          kind;
      fetch_info_t fi;
      rand_bits(2, r);
      // gap about one cycle in four
      fetch_valid <= (r[1:0] != 2'b00);
      // 13 supported kinds, the other 3 of 16 illegal
      rand_bits(4, r);
      kind = int'(r[3:0]);
      rand_bits(32, r);
      fi.inst = inst_word(kind, r);
      rand_bits(1, r);
      fi.br_taken = r[0];
      rand_bits(3, r);
      fi.exception = (r[2:0] == 3'b000);
      // raw code is random even without a fetch exception
      rand_bits(6, r);
      fi.exccode = r[5:0];
      rand_bits(HINT_W, r);
      fi.hint = r[HINT_W-1:0];
      fetch_info <= fi;
      stim_op    <= expected_op(kind);
      rand_bits(32, r);
      fetch_pc <= r;
      rand_bits(30, r);
      fetch_br_target <= r[29:0];
      rand_bits(3, r);
      irq <= (r[2:0] == 3'b000);
   endtask

   // model registers load like the stage, pending flag with set over clear
   always_ff @(posedge clk) begin
      if (rst) begin
         m_valid <= 1'b0;
         m_pc    <= '0;
         m_bt    <= '0;
         m_info  <= '0;
         // word 0 after reset is illegal
         m_op    <= '{OP_INE, BRU_NONE, 1'b0, 1'b0, IMM_SI12};
         m_pend  <= 1'b0;
      end else begin
         m_valid <= fetch_valid;
         if (fetch_valid) begin
            m_pc   <= fetch_pc;
            m_bt   <= fetch_br_target;
            m_info <= fetch_info;
            m_op   <= stim_op;
         end
         if (irq) begin
            m_pend <= 1'b1;
         end else if (m_valid && m_pend) begin
            m_pend <= 1'b0;
         end
      end
   end

   // any cause raises the bit
   assign exp_exc = m_pend | m_info.exception | (m_op.op_class == OP_SYSCALL) |
                    (m_op.op_class == OP_BREAK) | (m_op.op_class == OP_INE);

   // interrupt, fetch, sys, brk, ine
   always_comb begin
      if (m_pend) begin
         exp_code = EXC_INT;
      end else if (m_info.exception) begin
         exp_code = m_info.exccode;
      end else if (m_op.op_class == OP_SYSCALL) begin
         exp_code = EXC_SYS;
      end else if (m_op.op_class == OP_BREAK) begin
         exp_code = EXC_BRK;
      end else if (m_op.op_class == OP_INE) begin
         exp_code = EXC_INE;
      end else begin
         exp_code = 6'h00;
      end
   end

   assign exp_wen    = m_valid & m_op.gr_wen & ~exp_exc;
   assign exp_target = !exp_wen ? 5'd0 : (m_op.bru_code == BRU_BL) ? LINK_REG : m_info.inst[4:0];

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch on %s", name);
   endtask

   // first check after reset release
   assert property (@(posedge clk) $fell(rst) |-> (!dec_valid && !rf_wen))
      else begin
         $display("dec_valid or rf_wen was high right after reset");
         $display("TESTBENCH FAILED");
         $fatal(1, "reset state");
      end

   // per-cycle compare against the model
   assert property (@(posedge clk) disable iff (rst) dec_valid == m_valid)
      else report_mismatch("dec_valid", 64'($sampled(dec_valid)), 64'($sampled(m_valid)));
   assert property (@(posedge clk) disable iff (rst) dec_pc == m_pc)
      else report_mismatch("dec_pc", 64'($sampled(dec_pc)), 64'($sampled(m_pc)));
   assert property (@(posedge clk) disable iff (rst) dec_br_target == m_bt)
      else report_mismatch("dec_br_target", 64'($sampled(dec_br_target)), 64'($sampled(m_bt)));
   assert property (@(posedge clk) disable iff (rst) dec_info.inst == m_info.inst)
      else report_mismatch("dec_info.inst", 64'($sampled(dec_info.inst)),
                           64'($sampled(m_info.inst)));
   assert property (@(posedge clk) disable iff (rst) dec_info.br_taken == m_info.br_taken)
      else report_mismatch("dec_info.br_taken", 64'($sampled(dec_info.br_taken)),
                           64'($sampled(m_info.br_taken)));
   assert property (@(posedge clk) disable iff (rst) dec_info.hint == m_info.hint)
      else report_mismatch("dec_info.hint", 64'($sampled(dec_info.hint)),
                           64'($sampled(m_info.hint)));
   assert property (@(posedge clk) disable iff (rst) dec_info.exception == exp_exc)
      else report_mismatch("dec_info.exception", 64'($sampled(dec_info.exception)),
                           64'($sampled(exp_exc)));
   assert property (@(posedge clk) disable iff (rst) dec_info.exccode == exp_code)
      else report_mismatch("dec_info.exccode", 64'($sampled(dec_info.exccode)),
                           64'($sampled(exp_code)));
   assert property (@(posedge clk) disable iff (rst) dec_op.op_class == m_op.op_class)
      else report_mismatch("dec_op.op_class", 64'($sampled(dec_op.op_class)),
                           64'($sampled(m_op.op_class)));
   assert property (@(posedge clk) disable iff (rst) dec_op.bru_code == m_op.bru_code)
      else report_mismatch("dec_op.bru_code", 64'($sampled(dec_op.bru_code)),
                           64'($sampled(m_op.bru_code)));
   assert property (@(posedge clk) disable iff (rst) dec_op.gr_wen == m_op.gr_wen)
      else report_mismatch("dec_op.gr_wen", 64'($sampled(dec_op.gr_wen)),
                           64'($sampled(m_op.gr_wen)));
   assert property (@(posedge clk) disable iff (rst) dec_op.uses_imm == m_op.uses_imm)
      else report_mismatch("dec_op.uses_imm", 64'($sampled(dec_op.uses_imm)),
                           64'($sampled(m_op.uses_imm)));
   assert property (@(posedge clk) disable iff (rst) dec_op.imm_sel == m_op.imm_sel)
      else report_mismatch("dec_op.imm_sel", 64'($sampled(dec_op.imm_sel)),
                           64'($sampled(m_op.imm_sel)));
   assert property (@(posedge clk) disable iff (rst) rf_wen == exp_wen)
      else report_mismatch("rf_wen", 64'($sampled(rf_wen)), 64'($sampled(exp_wen)));
   assert property (@(posedge clk) disable iff (rst) rf_target == exp_target)
      else report_mismatch("rf_target", 64'($sampled(rf_target)), 64'($sampled(exp_target)));

   initial begin
      clk             = 1'b0;
      rst             = 1'b1;
      fetch_valid     = 1'b0;
      fetch_pc        = '0;
      fetch_br_target = '0;
      fetch_info      = '0;
      irq             = 1'b0;
      stim_op         = '{OP_INE, BRU_NONE, 1'b0, 1'b0, IMM_SI12};
      lfsr            = 16'd14;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      repeat (N_CYCLES) begin
         @(posedge clk);
         drive_cycle();
      end
      // drain the last packet and let the pending flag settle
      @(posedge clk);
      fetch_valid <= 1'b0;
      irq         <= 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      $display("TESTBENCH PASSED");
      $finish;
   end

   // watchdog
   initial begin
      #(TIMEOUT);
      $display("watchdog expired before the random sequence finished");
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
   end

endmodule

`default_nettype wire

// File: ifu_dec_top.f
hdl/dec_pkg.sv
hdl/inst_decoder.sv
hdl/int_pending.sv
hdl/ifu_dec_stage.sv
hdl/ifu_dec_top.sv
testbench/tb_ifu_dec_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_ifu_dec_top
FILELIST  := ifu_dec_top.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
